//--- rtl/core_pkg.sv
// Shared bus types, region codes, register offsets
// and default constants for the digital core
package core_pkg;

    //--------------------
    // Bus types
    //--------------------
    typedef logic [31:0] wb_data_t;   // Wishbone data word
    typedef logic [31:0] wb_addr_t;   // Wishbone byte address
    typedef logic [3:0]  wb_sel_t;    // Byte enables
    typedef logic [7:0]  reg_addr_t;  // Offset inside register block

    // Soft resets, all active low
    // bit 0 cpu, bit 1 spi, bit 2 sdram
    typedef logic [2:0]  rst_ctrl_t;

    typedef logic [2:0]  user_irq_t;  // User interrupt lines

    //--------------------
    // Region codes
    //--------------------
    // Taken from address bits 31..28
    localparam logic [3:0] REGION_SPIM  = 4'h1;  // Slave removed
    localparam logic [3:0] REGION_SDRAM = 4'h2;  // Slave removed
    localparam logic [3:0] REGION_GLBL  = 4'h3;  // Global config block

    //--------------------
    // Register offsets
    //--------------------
    localparam reg_addr_t REG_CTRL   = 8'h00;  // Soft resets [2:0]
    localparam reg_addr_t REG_CLK    = 8'h04;  // cpu ratio [3:0], rtc ratio [15:8]
    localparam reg_addr_t REG_IRQ    = 8'h08;  // user_irq [2:0]
    localparam reg_addr_t REG_IDCODE = 8'h0C;  // Read only

    // Field positions inside REG_CLK
    localparam int CLK_CPU_LSB = 0;
    localparam int CLK_RTC_LSB = 8;

    //--------------------
    // Defaults
    //--------------------
    // Device ID, overridden from the top level
    localparam wb_data_t DEF_IDCODE = 32'h1F5A_0C03;

endpackage : core_pkg

//--- rtl/clk_div.sv
// Programmable clock divider
// Output toggles every ratio+1 cycles, stopped low at ratio 0
module clk_div #(
    parameter int DIV_W = 4            // Ratio width
) (
    input  logic             wb_clk_i,
    input  logic             arst_n_i,
    input  logic [DIV_W-1:0] ratio_i,  // Half period minus one
    output logic             clk_o
);

    logic [DIV_W-1:0] cnt;       // Cycles since last toggle
    logic [DIV_W-1:0] ratio_q;   // Ratio in use, reloaded at toggle
    logic             stopped;

    assign stopped = (ratio_q == '0);

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt     <= '0;
            ratio_q <= '0;
            clk_o   <= 1'b0;
        end else if (stopped) begin
            // Held low, picks up a new ratio at once
            cnt     <= '0;
            ratio_q <= ratio_i;
            clk_o   <= 1'b0;
        end else if (cnt == ratio_q) begin
            cnt     <= '0;
            ratio_q <= ratio_i;               // New ratio from this toggle on
            clk_o   <= (ratio_i == '0) ? 1'b0 : !clk_o;   // Stop low
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule : clk_div

//--- rtl/glbl_cfg.sv
// Global configuration register block
// Soft resets, user interrupts, device ID and clock divider ratios
module glbl_cfg #(
    parameter core_pkg::wb_data_t DEVICE_IDCODE = core_pkg::DEF_IDCODE,
    parameter int                 CPU_DIV_W     = 4,   // At most 8
    parameter int                 RTC_DIV_W     = 8    // At most 24
) (
    input  logic                wb_clk_i,
    input  logic                arst_n_i,

    // Register bus
    input  logic                reg_cs_i,
    input  logic                reg_wr_i,
    input  core_pkg::reg_addr_t reg_addr_i,
    input  core_pkg::wb_data_t  reg_wdata_i,
    input  core_pkg::wb_sel_t   reg_be_i,
    output core_pkg::wb_data_t  reg_rdata_o,
    output logic                reg_ack_o,

    // Configuration outputs
    output core_pkg::rst_ctrl_t rst_ctrl_o,    // Active low soft resets
    output core_pkg::user_irq_t user_irq_o,
    output logic [CPU_DIV_W-1:0] cpu_ratio_o,
    output logic [RTC_DIV_W-1:0] rtc_ratio_o
);

    import core_pkg::*;

    //--------------------
    // Register images
    //--------------------
    wb_data_t ctrl_word;     // CTRL as a bus word
    wb_data_t clk_word;      // CLK as a bus word
    wb_data_t irq_word;      // IRQ as a bus word
    wb_data_t wmask;         // Byte enables spread to bits
    wb_data_t ctrl_nxt;      // Words after byte merge
    wb_data_t clk_nxt;
    wb_data_t irq_nxt;
    wb_data_t rd_word;       // Read mux result
    logic     wr_en;

    assign wr_en = reg_cs_i && reg_wr_i;

    assign wmask = {{8{reg_be_i[3]}}, {8{reg_be_i[2]}},
                    {8{reg_be_i[1]}}, {8{reg_be_i[0]}}};

    always_comb begin
        ctrl_word = '0;
        ctrl_word[$bits(rst_ctrl_t)-1:0] = rst_ctrl_o;
        irq_word = '0;
        irq_word[$bits(user_irq_t)-1:0] = user_irq_o;
        clk_word = '0;
        clk_word[CLK_CPU_LSB +: CPU_DIV_W] = cpu_ratio_o;
        clk_word[CLK_RTC_LSB +: RTC_DIV_W] = rtc_ratio_o;
    end

    // Byte merge of write data into current value
    always_comb begin
        ctrl_nxt = (ctrl_word & ~wmask) | (reg_wdata_i & wmask);
        clk_nxt  = (clk_word  & ~wmask) | (reg_wdata_i & wmask);
        irq_nxt  = (irq_word  & ~wmask) | (reg_wdata_i & wmask);
    end

    //--------------------
    // Write side
    //--------------------
    // Subsystems stay in reset and clocks stay stopped after reset
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_ctrl_o  <= '0;
            user_irq_o  <= '0;
            cpu_ratio_o <= '0;
            rtc_ratio_o <= '0;
        end else if (wr_en) begin
            case (reg_addr_i)
                REG_CTRL: rst_ctrl_o <= ctrl_nxt[$bits(rst_ctrl_t)-1:0];
                REG_IRQ:  user_irq_o <= irq_nxt[$bits(user_irq_t)-1:0];
                REG_CLK: begin
                    cpu_ratio_o <= clk_nxt[CLK_CPU_LSB +: CPU_DIV_W];
                    rtc_ratio_o <= clk_nxt[CLK_RTC_LSB +: RTC_DIV_W];
                end
                default: ;  // IDCODE and holes take no write
            endcase
        end
    end

    //--------------------
    // Read side
    //--------------------
    always_comb begin
        case (reg_addr_i)
            REG_CTRL:   rd_word = ctrl_word;
            REG_CLK:    rd_word = clk_word;
            REG_IRQ:    rd_word = irq_word;
            REG_IDCODE: rd_word = DEVICE_IDCODE;
            default:    rd_word = '0;   // Unlisted offset
        endcase
    end

    // Ack one cycle after select
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_ack_o <= 1'b0;
        end else begin
            reg_ack_o <= reg_cs_i;
        end
    end

    // Value before any write in the same access
    always_ff @(posedge wb_clk_i) begin
        if (reg_cs_i) begin
            reg_rdata_o <= reg_wr_i ? '0 : rd_word;
        end
    end

endmodule : glbl_cfg

//--- rtl/wb_intercon.sv
// Staged Wishbone interconnect for the external master
// Region decoder, register bus master and error responder
module wb_intercon (
    input  logic               wb_clk_i,       // System clock
    input  logic               arst_n_i,       // Async reset, active low

    // External master
    input  logic               wbd_ext_cyc_i,
    input  logic               wbd_ext_stb_i,
    input  core_pkg::wb_addr_t wbd_ext_adr_i,
    input  logic               wbd_ext_we_i,
    input  core_pkg::wb_data_t wbd_ext_dat_i,
    input  core_pkg::wb_sel_t  wbd_ext_sel_i,
    output core_pkg::wb_data_t wbd_ext_dat_o,
    output logic               wbd_ext_ack_o,
    output logic               wbd_ext_err_o,

    // Register bus to global config
    output logic                reg_cs_o,      // One cycle pulse
    output logic                reg_wr_o,
    output core_pkg::reg_addr_t reg_addr_o,
    output core_pkg::wb_data_t  reg_wdata_o,
    output core_pkg::wb_sel_t   reg_be_o,
    input  core_pkg::wb_data_t  reg_rdata_i,
    input  logic                reg_ack_i      // One cycle after reg_cs_o
);

    import core_pkg::*;

    //--------------------
    // Staging flop
    //--------------------
    logic       busy;          // Transfer in flight
    logic       accept;        // Request taken this edge
    logic       stg_vld;       // Staged request, one cycle
    logic [3:0] stg_region;    // Address bits 31..28
    reg_addr_t  stg_off;       // Byte offset in region
    logic       stg_we;
    wb_data_t   stg_dat;
    wb_sel_t    stg_sel;

    logic       hit_glbl;      // Staged address hits config block
    logic       err_d1;        // Error delay, stage 1
    logic       err_d2;        // Error delay, stage 2

    assign accept = wbd_ext_cyc_i && wbd_ext_stb_i && !busy;

    // Busy until the cycle after the response
    // master drops stb at the edge it sees ack or err
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy    <= 1'b0;
            stg_vld <= 1'b0;
        end else begin
            stg_vld <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (wbd_ext_ack_o || wbd_ext_err_o) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload, held stable while busy
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            stg_region <= wbd_ext_adr_i[31:28];
            stg_off    <= wbd_ext_adr_i[7:0];
            stg_we     <= wbd_ext_we_i;
            stg_dat    <= wbd_ext_dat_i;
            stg_sel    <= wbd_ext_sel_i;
        end
    end

    //--------------------
    // Region decode
    //--------------------
    always_comb begin
        case (stg_region)
            REGION_GLBL:  hit_glbl = 1'b1;
            REGION_SPIM:  hit_glbl = 1'b0;  // No SPI slave behind this
            REGION_SDRAM: hit_glbl = 1'b0;  // No SDRAM slave behind this
            default:      hit_glbl = 1'b0;  // Unmapped
        endcase
    end

    // Register bus, qualifiers straight from staging
    assign reg_wr_o    = stg_we;
    assign reg_addr_o  = stg_off;
    assign reg_wdata_o = stg_dat;
    assign reg_be_o    = stg_sel;

    // Chip select one cycle after staging, error delay runs alongside
    // so both paths answer on the same cycle
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_cs_o <= 1'b0;
            err_d1   <= 1'b0;
            err_d2   <= 1'b0;
        end else begin
            reg_cs_o <= stg_vld && hit_glbl;
            err_d1   <= stg_vld && !hit_glbl;
            err_d2   <= err_d1;                // Matches reg_ack_i slot
        end
    end

    //--------------------
    // Response to master
    //--------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wbd_ext_ack_o <= 1'b0;
            wbd_ext_err_o <= 1'b0;
        end else begin
            wbd_ext_ack_o <= reg_ack_i;
            wbd_ext_err_o <= err_d2;
        end
    end

    // Read data only alongside ack, zero otherwise
    always_ff @(posedge wb_clk_i) begin
        wbd_ext_dat_o <= reg_ack_i ? reg_rdata_i : '0;
    end

endmodule : wb_intercon

//--- rtl/digital_core.sv
// Top level of the digital core
// Interconnect, global config, cpu and rtc dividers, pad map
module digital_core #(
    parameter core_pkg::wb_data_t DEVICE_IDCODE = core_pkg::DEF_IDCODE,
    parameter int                 CPU_DIV_W     = 4,
    parameter int                 RTC_DIV_W     = 8
) (
    input  logic               wb_clk_i,       // System clock
    input  logic               arst_n_i,       // Async reset, active low

    // External Wishbone master
    input  logic               wbd_ext_cyc_i,
    input  logic               wbd_ext_stb_i,
    input  core_pkg::wb_addr_t wbd_ext_adr_i,
    input  logic               wbd_ext_we_i,
    input  core_pkg::wb_data_t wbd_ext_dat_i,
    input  core_pkg::wb_sel_t  wbd_ext_sel_i,
    output core_pkg::wb_data_t wbd_ext_dat_o,
    output logic               wbd_ext_ack_o,
    output logic               wbd_ext_err_o,

    // Pads
    output logic [37:0]        io_out_o,
    output logic [37:0]        io_oeb_o,       // Low drives the pad

    output core_pkg::user_irq_t user_irq_o
);

    import core_pkg::*;

    //--------------------
    // Register bus
    //--------------------
    logic      reg_cs;
    logic      reg_wr;
    reg_addr_t reg_addr;
    wb_data_t  reg_wdata;
    wb_sel_t   reg_be;
    wb_data_t  reg_rdata;
    logic      reg_ack;

    // Configuration
    rst_ctrl_t            rst_ctrl;      // cpu, spi, sdram resets
    logic [CPU_DIV_W-1:0] cpu_ratio;
    logic [RTC_DIV_W-1:0] rtc_ratio;
    logic                 cpu_clk;
    logic                 rtc_clk;

    wb_intercon u_intercon (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .wbd_ext_cyc_i (wbd_ext_cyc_i),
        .wbd_ext_stb_i (wbd_ext_stb_i),
        .wbd_ext_adr_i (wbd_ext_adr_i),
        .wbd_ext_we_i  (wbd_ext_we_i),
        .wbd_ext_dat_i (wbd_ext_dat_i),
        .wbd_ext_sel_i (wbd_ext_sel_i),
        .wbd_ext_dat_o (wbd_ext_dat_o),
        .wbd_ext_ack_o (wbd_ext_ack_o),
        .wbd_ext_err_o (wbd_ext_err_o),
        .reg_cs_o      (reg_cs),
        .reg_wr_o      (reg_wr),
        .reg_addr_o    (reg_addr),
        .reg_wdata_o   (reg_wdata),
        .reg_be_o      (reg_be),
        .reg_rdata_i   (reg_rdata),
        .reg_ack_i     (reg_ack)
    );

    glbl_cfg #(
        .DEVICE_IDCODE (DEVICE_IDCODE),
        .CPU_DIV_W     (CPU_DIV_W),
        .RTC_DIV_W     (RTC_DIV_W)
    ) u_glbl_cfg (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .reg_cs_i      (reg_cs),
        .reg_wr_i      (reg_wr),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .reg_be_i      (reg_be),
        .reg_rdata_o   (reg_rdata),
        .reg_ack_o     (reg_ack),
        .rst_ctrl_o    (rst_ctrl),
        .user_irq_o    (user_irq_o),    // Straight to the user irq pins
        .cpu_ratio_o   (cpu_ratio),
        .rtc_ratio_o   (rtc_ratio)
    );

    clk_div #(.DIV_W(CPU_DIV_W)) u_cpu_clk (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .ratio_i  (cpu_ratio),
        .clk_o    (cpu_clk)
    );

    clk_div #(.DIV_W(RTC_DIV_W)) u_rtc_clk (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .ratio_i  (rtc_ratio),
        .clk_o    (rtc_clk)
    );

    //--------------------
    // Pad map
    //--------------------
    assign io_out_o = {33'b0, rtc_clk, cpu_clk, rst_ctrl};  // [4] rtc, [3] cpu, [2:0] resets
    assign io_oeb_o = {{33{1'b1}}, 5'b0};                   // Only bits 4..0 driven

endmodule : digital_core

//--- sim/digital_core_chk.sv
// Concurrent assertions on the external bus response
// Bound into wb_intercon
module digital_core_chk (
    input logic clk_i,
    input logic arst_n_i,
    input logic accept_i,     // Request taken this edge
    input logic ack_i,
    input logic err_i
);

    localparam int RESP_DLY = 3;   // Edges from acceptance to ack or err

    int fail_cnt = 0;         // Assertion failures so far

    // Never both at once
    ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ack_i && err_i))
        else begin
            $error("ack and err high in the same cycle");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_i |=> !ack_i)
        else begin
            $error("ack longer than one cycle");
            fail_cnt++;
        end

    err_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        err_i |=> !err_i)
        else begin
            $error("err longer than one cycle");
            fail_cnt++;
        end

    // Three edges from acceptance, both ways round
    // Response set on that edge is first sampled one edge later
    resp_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(accept_i, RESP_DLY + 1) |-> (ack_i || err_i))
        else begin
            $error("no response three cycles after acceptance");
            fail_cnt++;
        end

    resp_has_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ack_i || err_i) |-> $past(accept_i, RESP_DLY + 1))
        else begin
            $error("response without a request three cycles before");
            fail_cnt++;
        end

endmodule : digital_core_chk

bind wb_intercon digital_core_chk u_chk (
    .clk_i    (wb_clk_i),
    .arst_n_i (arst_n_i),
    .accept_i (accept),
    .ack_i    (wbd_ext_ack_o),
    .err_i    (wbd_ext_err_o)
);

//--- sim/tb_digital_core.sv
// Testbench for the digital core
// Clock and reset, Wishbone master tasks, compare tasks, directed tests
module tb_digital_core;

    import core_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int RESP_CYCLES  = 3;          // Acceptance to ack or err
    // About 60 transfers of 6 cycles plus two divider runs, wide margin
    localparam int TIMEOUT_CYCLES = 5000;
    localparam logic [37:0] OEB_EXP = ~38'h1F;   // Pads 4..0 driven

    logic        wb_clk;
    logic        arst_n;
    logic        wbd_cyc;
    logic        wbd_stb;
    wb_addr_t    wbd_adr;
    logic        wbd_we;
    wb_data_t    wbd_wdat;
    wb_sel_t     wbd_sel;
    wb_data_t    wbd_rdat;
    logic        wbd_ack;
    logic        wbd_err;
    logic [37:0] io_out;
    logic [37:0] io_oeb;
    user_irq_t   user_irq;

    int          cycle_cnt = 0;
    rst_ctrl_t   exp_rst;                     // Register model
    user_irq_t   exp_irq;

    digital_core dut_i (
        .wb_clk_i      (wb_clk),
        .arst_n_i      (arst_n),
        .wbd_ext_cyc_i (wbd_cyc),
        .wbd_ext_stb_i (wbd_stb),
        .wbd_ext_adr_i (wbd_adr),
        .wbd_ext_we_i  (wbd_we),
        .wbd_ext_dat_i (wbd_wdat),
        .wbd_ext_sel_i (wbd_sel),
        .wbd_ext_dat_o (wbd_rdat),
        .wbd_ext_ack_o (wbd_ack),
        .wbd_ext_err_o (wbd_err),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .user_irq_o    (user_irq)
    );

    always #4 wb_clk = ~wb_clk;               // Period 8

    always @(posedge wb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not end within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //--------------------
    // Helpers
    //--------------------
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic wb_addr_t glbl_addr(input reg_addr_t off);
        return {REGION_GLBL, 20'h0, off};
    endfunction

    // Byte lanes with sel set take the new data
    function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
                                             input wb_sel_t sel);
        wb_data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // [4] rtc clock, [3] cpu clock, [2:0] soft resets
    function automatic logic [37:0] pad_out(input rst_ctrl_t rst, input logic cpu,
                                           input logic rtc);
        logic [37:0] pads;
        pads      = '0;
        pads[2:0] = rst;
        pads[3]   = cpu;
        pads[4]   = rtc;
        return pads;
    endfunction

    task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            $display("error: %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rst(input rst_ctrl_t got, input rst_ctrl_t exp, input string what);
        if (got !== exp) begin
            $display("error: %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_irq(input user_irq_t got, input user_irq_t exp, input string what);
        if (got !== exp) begin
            $display("error: %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("error: %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pads(input logic [37:0] got, input logic [37:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("error: %0t: %s got 0x%010h expected 0x%010h", $time, what, got, exp);
            abort_run();
        end
    endtask

    //--------------------
    // Bus master
    //--------------------
    // Counts rising edges from acceptance to the one that sets ack or err
    task automatic bus_transfer(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                                input wb_sel_t sel, input logic exp_err,
                                output wb_data_t rdat);
        int cycles;
        @(posedge wb_clk);
        wbd_cyc  <= 1'b1;
        wbd_stb  <= 1'b1;
        wbd_adr  <= adr;
        wbd_we   <= we;
        wbd_wdat <= wdat;
        wbd_sel  <= sel;
        @(posedge wb_clk);                    // Accepted here, interconnect idle
        cycles = 0;
        @(negedge wb_clk);                    // Still the acceptance cycle
        while (!(wbd_ack || wbd_err) && cycles < RESP_CYCLES + 8) begin
            @(negedge wb_clk);
            cycles++;
        end
        if (!(wbd_ack || wbd_err)) begin
            $display("No ack or err from the bus within %0d cycles", cycles);
            abort_run();
        end
        check_count(cycles, RESP_CYCLES, "response latency");
        check_count(int'(wbd_err), int'(exp_err), "err");
        check_count(int'(wbd_ack), int'(!exp_err), "ack");
        if (exp_err)
            check_data(wbd_rdat, '0, "read data with err");
        rdat = wbd_rdat;
        @(posedge wb_clk);                    // Drop stb after the response
        wbd_cyc <= 1'b0;
        wbd_stb <= 1'b0;
        wbd_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel,
                            input logic exp_err);
        wb_data_t rdat;
        bus_transfer(adr, 1'b1, wdat, sel, exp_err, rdat);
    endtask

    task automatic wb_read(input wb_addr_t adr, input logic exp_err, output wb_data_t rdat);
        bus_transfer(adr, 1'b0, '0, 4'hF, exp_err, rdat);
    endtask

    // Readback and pins against the model
    task automatic check_model();
        wb_data_t rdat;
        wb_read(glbl_addr(REG_IRQ), 1'b0, rdat);
        check_data(rdat, {29'b0, exp_irq}, "IRQ readback");
        wb_read(glbl_addr(REG_CTRL), 1'b0, rdat);
        check_data(rdat, {29'b0, exp_rst}, "CTRL readback");
        check_irq(user_irq, exp_irq, "user_irq pins");
        check_rst(io_out[2:0], exp_rst, "soft reset pads");
    endtask

    //--------------------
    // Directed tests
    //--------------------
    task automatic test_reset_state();
        @(negedge wb_clk);
        check_count(int'(wbd_ack), 0, "ack after reset");
        check_count(int'(wbd_err), 0, "err after reset");
        check_pads(io_out, pad_out('0, 1'b0, 1'b0), "io_out after reset");
        check_pads(io_oeb, OEB_EXP, "io_oeb");
        check_irq(user_irq, '0, "user_irq after reset");
    endtask

    task automatic test_registers();
        wb_data_t wdat;
        wb_data_t merged;
        wb_sel_t  sel;
        int       i;
        for (i = 0; i < 8; i++) begin
            case (i % 4)
                0:       sel = 4'hF;
                1:       sel = 4'h1;
                2:       sel = 4'hE;          // Misses the implemented byte
                default: sel = wb_sel_t'($urandom);
            endcase
            wdat = $urandom;
            wb_write(glbl_addr(REG_IRQ), wdat, sel, 1'b0);
            merged  = merge_bytes({29'b0, exp_irq}, wdat, sel);
            exp_irq = merged[2:0];
            wdat = $urandom;
            wb_write(glbl_addr(REG_CTRL), wdat, sel, 1'b0);
            merged  = merge_bytes({29'b0, exp_rst}, wdat, sel);
            exp_rst = merged[2:0];
            check_model();
        end
    endtask

    task automatic test_idcode();
        wb_data_t rdat;
        wb_read(glbl_addr(REG_IDCODE), 1'b0, rdat);
        check_data(rdat, DEF_IDCODE, "IDCODE");
        wb_write(glbl_addr(REG_IDCODE), $urandom, 4'hF, 1'b0);
        wb_read(glbl_addr(REG_IDCODE), 1'b0, rdat);
        check_data(rdat, DEF_IDCODE, "IDCODE after write");
        wb_write(glbl_addr(8'h20), $urandom, 4'hF, 1'b0);   // Acked, no effect
        wb_read(glbl_addr(8'h20), 1'b0, rdat);
        check_data(rdat, '0, "offset 0x20");
        check_model();
    endtask

    task automatic test_unmapped();
        wb_data_t rdat;
        wb_addr_t adr;
        int       i;
        for (i = 0; i < 3; i++) begin
            case (i)
                0:       adr = {REGION_SPIM, 20'h0, REG_IRQ};
                1:       adr = {REGION_SDRAM, 20'h0, REG_CTRL};
                default: adr = {4'hF, 20'h0, REG_IRQ};
            endcase
            wb_write(adr, $urandom, 4'hF, 1'b1);
            wb_read(adr, 1'b1, rdat);
        end
        check_model();                        // Nothing reached the registers
    endtask

    // Negedges between two rising edges of one pad
    task automatic measure_period(input int bit_idx, output int period);
        logic prev;
        logic found;
        found = 1'b0;
        prev  = io_out[bit_idx];
        while (!found) begin
            @(negedge wb_clk);
            found = !prev && io_out[bit_idx];
            prev  = io_out[bit_idx];
        end
        period = 0;
        found  = 1'b0;
        while (!found) begin
            @(negedge wb_clk);
            period++;
            found = !prev && io_out[bit_idx];
            prev  = io_out[bit_idx];
        end
    endtask

    task automatic test_clock_dividers();
        wb_data_t rdat;
        int       period;
        int       i;
        // rtc 5 in [15:8], cpu 2 in [3:0], rest unimplemented
        wb_write(glbl_addr(REG_CLK), 32'hDEAD_05F2, 4'hF, 1'b0);
        wb_read(glbl_addr(REG_CLK), 1'b0, rdat);
        check_data(rdat, 32'h0000_0502, "CLK readback");
        measure_period(3, period);
        check_count(period, 2 * (2 + 1), "cpu clock period");
        measure_period(4, period);
        check_count(period, 2 * (5 + 1), "rtc clock period");
        wb_write(glbl_addr(REG_CLK), 32'h0, 4'hF, 1'b0);
        repeat (2 * (5 + 1)) @(negedge wb_clk);   // Up to the next toggle
        for (i = 0; i < 24; i++) begin
            @(negedge wb_clk);
            check_pads(io_out, pad_out(exp_rst, 1'b0, 1'b0), "pads with clocks stopped");
        end
    endtask

    initial begin
        void'($urandom(67));
        wb_clk   = 1'b0;
        arst_n   = 1'b0;
        wbd_cyc  = 1'b0;
        wbd_stb  = 1'b0;
        wbd_adr  = '0;
        wbd_we   = 1'b0;
        wbd_wdat = '0;
        wbd_sel  = '0;
        exp_rst  = '0;
        exp_irq  = '0;
        repeat (RESET_CYCLES) @(posedge wb_clk);
        arst_n <= 1'b1;
        test_reset_state();
        test_registers();
        test_idcode();
        test_unmapped();
        test_clock_dividers();
        @(negedge wb_clk);
        if (dut_i.u_intercon.u_chk.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Bus response assertions failed %0d times",
                     dut_i.u_intercon.u_chk.fail_cnt);
            abort_run();
        end
    end

endmodule : tb_digital_core

//--- filelist.f
rtl/core_pkg.sv
rtl/clk_div.sv
rtl/glbl_cfg.sv
rtl/wb_intercon.sv
rtl/digital_core.sv
sim/digital_core_chk.sv
sim/tb_digital_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_digital_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
